// ==== fpu.f ====
+incdir+test
logic/fp_pkg.sv
logic/fp_sign_minmax.sv
logic/fp_compare_classify.sv
logic/fp_result_stage.sv
logic/fpu_top.sv
test/fpu_tb.sv

// ==== logic/fp_compare_classify.sv ====
// Compare and classify datapath producing an integer result and invalid flag
module fp_compare_classify (
  input  fp_pkg::fp_op_e    op,         // Requested operation
  input  fp_pkg::fp_word_t  operand_a,  // rs1, also the FCLASS source
  input  fp_pkg::fp_word_t  operand_b,  // rs2
  output fp_pkg::int_word_t cc_result,  // 0/1 for compares, class mask for FCLASS
  output logic              cc_nv       // Invalid flag
);

  // ========================================
  // Operand field decode
  // ========================================
  logic                                           sign_a;
  logic                                           sign_b;
  logic [fp_pkg::EXP_WIDTH-1:0]                   exp_a;
  logic [fp_pkg::MAN_WIDTH-1:0]                   man_a;
  logic [fp_pkg::EXP_WIDTH+fp_pkg::MAN_WIDTH-1:0] mag_a;
  logic [fp_pkg::EXP_WIDTH+fp_pkg::MAN_WIDTH-1:0] mag_b;
  logic                                           nan_a;
  logic                                           nan_b;
  logic                                           any_nan;
  logic                                           any_snan;
  logic                                           both_zero;  // +0 and -0 compare equal
  logic                                           ord_eq;
  logic                                           ord_lt;
  logic [fp_pkg::CLASS_WIDTH-1:0]                 class_mask;

  assign sign_a = operand_a[fp_pkg::EXP_WIDTH+fp_pkg::MAN_WIDTH];
  assign sign_b = operand_b[fp_pkg::EXP_WIDTH+fp_pkg::MAN_WIDTH];
  assign exp_a  = operand_a[fp_pkg::MAN_WIDTH +: fp_pkg::EXP_WIDTH];
  assign man_a  = operand_a[fp_pkg::MAN_WIDTH-1:0];
  assign mag_a  = operand_a[fp_pkg::EXP_WIDTH+fp_pkg::MAN_WIDTH-1:0];
  assign mag_b  = operand_b[fp_pkg::EXP_WIDTH+fp_pkg::MAN_WIDTH-1:0];

  assign nan_a = (exp_a == fp_pkg::EXP_MAX) && (man_a != '0);
  assign nan_b = (operand_b[fp_pkg::MAN_WIDTH +: fp_pkg::EXP_WIDTH] == fp_pkg::EXP_MAX) &&
                 (operand_b[fp_pkg::MAN_WIDTH-1:0] != '0);

  assign any_nan  = nan_a | nan_b;
  assign any_snan = (nan_a && !operand_a[fp_pkg::QUIET_BIT]) ||
                    (nan_b && !operand_b[fp_pkg::QUIET_BIT]);

  assign both_zero = (mag_a == '0) && (mag_b == '0);

  // Ordered relations, valid only when neither operand is NaN
  assign ord_eq = (operand_a == operand_b) || both_zero;

  always_comb begin
    if (both_zero) begin
      ord_lt = 1'b0;            // Zero pair never ordered by sign
    end else if (sign_a != sign_b) begin
      ord_lt = sign_a;          // Negative side below
    end else if (sign_a) begin
      ord_lt = (mag_a > mag_b); // Both negative, order flips
    end else begin
      ord_lt = (mag_a < mag_b);
    end
  end

  // ========================================
  // FCLASS one-hot mask of operand a
  // ========================================
  always_comb begin
    class_mask = '0;
    if (exp_a == fp_pkg::EXP_MAX) begin
      if (man_a == '0) begin
        class_mask[sign_a ? fp_pkg::CLS_NEG_INF : fp_pkg::CLS_POS_INF] = 1'b1;
      end else if (man_a[fp_pkg::QUIET_BIT]) begin
        class_mask[fp_pkg::CLS_QNAN] = 1'b1;
      end else begin
        class_mask[fp_pkg::CLS_SNAN] = 1'b1;
      end
    end else if (exp_a == '0) begin
      // Zero exponent: zero or subnormal
      if (man_a == '0) begin
        class_mask[sign_a ? fp_pkg::CLS_NEG_ZERO : fp_pkg::CLS_POS_ZERO] = 1'b1;
      end else begin
        class_mask[sign_a ? fp_pkg::CLS_NEG_SUB : fp_pkg::CLS_POS_SUB] = 1'b1;
      end
    end else begin
      class_mask[sign_a ? fp_pkg::CLS_NEG_NORM : fp_pkg::CLS_POS_NORM] = 1'b1;
    end
  end

  // ========================================
  // Result select
  // ========================================
  always_comb begin
    cc_result = '0;
    cc_nv     = 1'b0;
    case (op)
      fp_pkg::OP_FEQ: begin
        cc_result = {31'd0, ord_eq & ~any_nan};
        cc_nv     = any_snan;  // Quiet compare
      end
      fp_pkg::OP_FLT: begin
        cc_result = {31'd0, ord_lt & ~any_nan};
        cc_nv     = any_nan;   // Signaling compare
      end
      fp_pkg::OP_FLE: begin
        cc_result = {31'd0, (ord_lt | ord_eq) & ~any_nan};
        cc_nv     = any_nan;
      end
      fp_pkg::OP_FCLASS: cc_result = {{(32-fp_pkg::CLASS_WIDTH){1'b0}}, class_mask};
      default: begin
        cc_result = '0;
        cc_nv     = 1'b0;
      end
    endcase
  end

endmodule

// ==== logic/fp_pkg.sv ====
// FPU package with word types, operation enum, class-mask positions and NaN constants
package fp_pkg;

  // ========================================
  // Field widths of the single-precision word
  // ========================================
  localparam int EXP_WIDTH = 8;   // Biased exponent
  localparam int MAN_WIDTH = 23;  // Stored fraction, hidden bit not included

  // All-ones exponent, shared by infinity and NaN
  localparam logic [EXP_WIDTH-1:0] EXP_MAX = 8'd255;

  // Fraction MSB, set for quiet NaN and clear for signaling NaN
  localparam int QUIET_BIT = 22;

  // Raw FP bit pattern and integer register value
  typedef logic [EXP_WIDTH+MAN_WIDTH:0] fp_word_t;  // sign + exponent + fraction
  typedef logic [31:0]                  int_word_t;

  // Default quiet NaN returned when no operand can be passed through
  localparam fp_word_t CANONICAL_NAN = 32'h7FC0_0000;

  // ========================================
  // Operation codes
  // ========================================
  typedef enum logic [3:0] {
    OP_FSGNJ   = 4'd0,   // Sign from b
    OP_FSGNJN  = 4'd1,   // Inverted sign from b
    OP_FSGNJX  = 4'd2,   // XOR of both signs
    OP_FMIN    = 4'd3,
    OP_FMAX    = 4'd4,
    OP_FEQ     = 4'd5,   // Quiet compare
    OP_FLT     = 4'd6,   // Signaling compare
    OP_FLE     = 4'd7,   // Signaling compare
    OP_FCLASS  = 4'd8,   // One-hot class mask of a
    OP_FMV_X_W = 4'd9,   // FP bits to integer side
    OP_FMV_W_X = 4'd10   // Integer bits to FP side
  } fp_op_e;

  // ========================================
  // FCLASS mask bit positions
  // ========================================
  localparam int CLASS_WIDTH  = 10;

  localparam int CLS_NEG_INF  = 0;
  localparam int CLS_NEG_NORM = 1;
  localparam int CLS_NEG_SUB  = 2;
  localparam int CLS_NEG_ZERO = 3;
  localparam int CLS_POS_ZERO = 4;
  localparam int CLS_POS_SUB  = 5;
  localparam int CLS_POS_NORM = 6;
  localparam int CLS_POS_INF  = 7;
  localparam int CLS_SNAN     = 8;  // Signaling NaN, either sign
  localparam int CLS_QNAN     = 9;  // Quiet NaN, either sign

endpackage

// ==== logic/fp_result_stage.sv ====
// Result select, move operations, output registers, done pulse and sticky invalid flag
module fp_result_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,        // One request per high cycle
  input  fp_pkg::fp_op_e    op,
  input  fp_pkg::fp_word_t  sm_result,    // Sign/min-max datapath
  input  logic              sm_nv,
  input  fp_pkg::int_word_t cc_result,    // Compare/classify datapath
  input  logic              cc_nv,
  input  fp_pkg::fp_word_t  operand_a,    // FMV.X.W source
  input  fp_pkg::int_word_t int_operand,  // FMV.W.X source
  input  logic              nv_clear,     // Clears the sticky flag
  output logic              done,         // One pulse per request
  output fp_pkg::fp_word_t  fp_result,
  output fp_pkg::int_word_t int_result,
  output logic              op_nv,        // Invalid flag of the completed op
  output logic              nv_sticky     // Accumulated invalid flag
);

  // ========================================
  // Per-operation result select
  // ========================================
  fp_pkg::fp_word_t  sel_fp;
  fp_pkg::int_word_t sel_int;
  logic              sel_nv;

  // Unused result side stays zero
  always_comb begin
    sel_fp  = '0;
    sel_int = '0;
    sel_nv  = 1'b0;
    case (op)
      fp_pkg::OP_FSGNJ, fp_pkg::OP_FSGNJN, fp_pkg::OP_FSGNJX,
      fp_pkg::OP_FMIN, fp_pkg::OP_FMAX: begin
        sel_fp = sm_result;
        sel_nv = sm_nv;    // Always 0 for sign injection
      end
      fp_pkg::OP_FEQ, fp_pkg::OP_FLT, fp_pkg::OP_FLE, fp_pkg::OP_FCLASS: begin
        sel_int = cc_result;
        sel_nv  = cc_nv;   // Always 0 for FCLASS
      end
      // Bit moves, no conversion and no flags
      fp_pkg::OP_FMV_X_W: sel_int = operand_a;
      fp_pkg::OP_FMV_W_X: sel_fp  = int_operand;
      default: begin
        sel_fp  = '0;
        sel_int = '0;
        sel_nv  = 1'b0;
      end
    endcase
  end

  // ========================================
  // Output registers
  // ========================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done  <= 1'b0;
      op_nv <= 1'b0;
    end else begin
      done  <= start;           // Single-cycle pulse per start
      op_nv <= start & sel_nv;  // Low outside a done cycle
    end
  end

  // Results only meaningful while done is high
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fp_result  <= '0;
      int_result <= '0;
    end else if (start) begin
      fp_result  <= sel_fp;
      int_result <= sel_int;
    end
  end

  // Sticky flag: clear first, then OR in the flag of the op completing now
  // A clear and an invalid completion at the same edge leave it set
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      nv_sticky <= 1'b0;
    end else begin
      nv_sticky <= (nv_sticky & ~nv_clear) | op_nv;
    end
  end

endmodule

// ==== logic/fp_sign_minmax.sv ====
// Sign injection and min/max datapath with signaling-NaN invalid flag
module fp_sign_minmax (
  input  fp_pkg::fp_op_e   op,         // Requested operation
  input  fp_pkg::fp_word_t operand_a,  // rs1
  input  fp_pkg::fp_word_t operand_b,  // rs2
  output fp_pkg::fp_word_t sm_result,  // FP result, zero for other ops
  output logic             sm_nv       // Invalid flag, min/max only
);

  // ========================================
  // Operand field decode
  // ========================================
  logic                                              sign_a;
  logic                                              sign_b;
  logic [fp_pkg::EXP_WIDTH+fp_pkg::MAN_WIDTH-1:0]    mag_a;   // Exponent and fraction
  logic [fp_pkg::EXP_WIDTH+fp_pkg::MAN_WIDTH-1:0]    mag_b;
  logic                                              nan_a;
  logic                                              nan_b;
  logic                                              snan_a;
  logic                                              snan_b;
  logic                                              a_lt_b;  // Total order, -0 below +0
  logic                                              is_max;

  assign sign_a = operand_a[fp_pkg::EXP_WIDTH+fp_pkg::MAN_WIDTH];
  assign sign_b = operand_b[fp_pkg::EXP_WIDTH+fp_pkg::MAN_WIDTH];
  assign mag_a  = operand_a[fp_pkg::EXP_WIDTH+fp_pkg::MAN_WIDTH-1:0];
  assign mag_b  = operand_b[fp_pkg::EXP_WIDTH+fp_pkg::MAN_WIDTH-1:0];

  // NaN: exponent all ones with a nonzero fraction
  assign nan_a = (operand_a[fp_pkg::MAN_WIDTH +: fp_pkg::EXP_WIDTH] == fp_pkg::EXP_MAX) &&
                 (operand_a[fp_pkg::MAN_WIDTH-1:0] != '0);
  assign nan_b = (operand_b[fp_pkg::MAN_WIDTH +: fp_pkg::EXP_WIDTH] == fp_pkg::EXP_MAX) &&
                 (operand_b[fp_pkg::MAN_WIDTH-1:0] != '0);

  // Signaling when the quiet bit is clear
  assign snan_a = nan_a && !operand_a[fp_pkg::QUIET_BIT];
  assign snan_b = nan_b && !operand_b[fp_pkg::QUIET_BIT];

  // Sign-magnitude ordering
  // Differing signs: the negative one is smaller, which also puts -0 under +0
  // Both negative: the larger magnitude is the smaller value
  always_comb begin
    if (sign_a != sign_b) begin
      a_lt_b = sign_a;
    end else if (sign_a) begin
      a_lt_b = (mag_a > mag_b);
    end else begin
      a_lt_b = (mag_a < mag_b);
    end
  end

  assign is_max = (op == fp_pkg::OP_FMAX);

  // ========================================
  // Result select
  // ========================================
  always_comb begin
    sm_result = '0;  // Ops outside this datapath
    sm_nv     = 1'b0;
    case (op)
      // Magnitude of a always kept, only the sign source changes
      fp_pkg::OP_FSGNJ:  sm_result = {sign_b, mag_a};
      fp_pkg::OP_FSGNJN: sm_result = {~sign_b, mag_a};
      fp_pkg::OP_FSGNJX: sm_result = {sign_a ^ sign_b, mag_a};

      fp_pkg::OP_FMIN, fp_pkg::OP_FMAX: begin
        sm_nv = snan_a | snan_b;  // Quiet NaNs raise nothing
        if (nan_a && nan_b) begin
          sm_result = fp_pkg::CANONICAL_NAN;
        end else if (nan_a) begin
          sm_result = operand_b;  // NaN loses to a number
        end else if (nan_b) begin
          sm_result = operand_a;
        end else begin
          // Min keeps a when smaller, max keeps a when not smaller
          sm_result = (a_lt_b ^ is_max) ? operand_a : operand_b;
        end
      end

      default: begin
        sm_result = '0;
        sm_nv     = 1'b0;
      end
    endcase
  end

endmodule

// ==== logic/fpu_top.sv ====
// FPU top level joining the sign/min-max and compare/classify datapaths to the result stage
module fpu_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,        // Request strobe, no back-pressure
  input  fp_pkg::fp_op_e    op,
  input  fp_pkg::fp_word_t  operand_a,
  input  fp_pkg::fp_word_t  operand_b,
  input  fp_pkg::int_word_t int_operand,  // FMV.W.X only
  input  logic              nv_clear,
  output logic              done,
  output fp_pkg::fp_word_t  fp_result,
  output fp_pkg::int_word_t int_result,
  output logic              op_nv,
  output logic              nv_sticky
);

  // ========================================
  // Combinational datapaths
  // ========================================
  fp_pkg::fp_word_t  sm_result;
  logic              sm_nv;
  fp_pkg::int_word_t cc_result;
  logic              cc_nv;

  // FP-result ops: sign injection, min, max
  fp_sign_minmax i_sign_minmax (
    .op        (op),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .sm_result (sm_result),
    .sm_nv     (sm_nv)
  );

  // Integer-result ops: compares and classify
  fp_compare_classify i_compare_classify (
    .op        (op),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .cc_result (cc_result),
    .cc_nv     (cc_nv)
  );

  // ========================================
  // Registered result stage
  // ========================================
  fp_result_stage i_result_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .op          (op),
    .sm_result   (sm_result),
    .sm_nv       (sm_nv),
    .cc_result   (cc_result),
    .cc_nv       (cc_nv),
    .operand_a   (operand_a),   // Moves bypass the datapaths
    .int_operand (int_operand),
    .nv_clear    (nv_clear),
    .done        (done),
    .fp_result   (fp_result),
    .int_result  (int_result),
    .op_nv       (op_nv),
    .nv_sticky   (nv_sticky)
  );

endmodule

// ==== test/fpu_vectors.svh ====
// Stimulus and expected-value table of the FPU testbench, loaded by a task
`ifndef FPU_VECTORS_SVH
`define FPU_VECTORS_SVH

// Columns: op, operand_a, operand_b, int_operand, nv_clear,
//          expected fp_result, expected int_result, expected op_nv
task automatic load_table();
  // Sign injection
  add_vec(fp_pkg::OP_FSGNJ,   'h3F800000, 'hC0000000, 'h0, 1'b0, 'hBF800000, 'h0, 1'b0);
  add_vec(fp_pkg::OP_FSGNJN,  'h3F800000, 'hC0000000, 'h0, 1'b0, 'h3F800000, 'h0, 1'b0);
  add_vec(fp_pkg::OP_FSGNJX,  'hBF800000, 'hC0000000, 'h0, 1'b0, 'h3F800000, 'h0, 1'b0);
  // Min and max, ordinary values and signed zero
  add_vec(fp_pkg::OP_FMIN,    'h3F800000, 'h40000000, 'h0, 1'b0, 'h3F800000, 'h0, 1'b0);
  add_vec(fp_pkg::OP_FMAX,    'h3F800000, 'h40000000, 'h0, 1'b0, 'h40000000, 'h0, 1'b0);
  add_vec(fp_pkg::OP_FMIN,    'hBF800000, 'hC0000000, 'h0, 1'b0, 'hC0000000, 'h0, 1'b0);
  add_vec(fp_pkg::OP_FMIN,    'h00000000, 'h80000000, 'h0, 1'b0, 'h80000000, 'h0, 1'b0);
  add_vec(fp_pkg::OP_FMAX,    'h80000000, 'h00000000, 'h0, 1'b0, 'h00000000, 'h0, 1'b0);
  // NaN handling
  add_vec(fp_pkg::OP_FMIN,    'h7FC00000, 'h40000000, 'h0, 1'b0, 'h40000000, 'h0, 1'b0);
  add_vec(fp_pkg::OP_FMAX,    'h3F800000, 'hFFC00000, 'h0, 1'b0, 'h3F800000, 'h0, 1'b0);
  add_vec(fp_pkg::OP_FMAX,    'h7FC12345, 'hFFC00001, 'h0, 1'b0, 'h7FC00000, 'h0, 1'b0);
  add_vec(fp_pkg::OP_FMIN,    'h7F800001, 'h3F800000, 'h0, 1'b0, 'h3F800000, 'h0, 1'b1);
  // Clear meets the sNaN flag at the same edge, sticky stays set
  add_vec(fp_pkg::OP_FEQ,     'h3F800000, 'h3F800000, 'h0, 1'b1, 'h0, 'h1, 1'b0);
  // Compares
  add_vec(fp_pkg::OP_FLT,     'h3F800000, 'h40000000, 'h0, 1'b0, 'h0, 'h1, 1'b0);
  add_vec(fp_pkg::OP_FLE,     'h40000000, 'h40000000, 'h0, 1'b0, 'h0, 'h1, 1'b0);
  add_vec(fp_pkg::OP_FLT,     'h40000000, 'h3F800000, 'h0, 1'b0, 'h0, 'h0, 1'b0);
  add_vec(fp_pkg::OP_FLT,     'hC0000000, 'hBF800000, 'h0, 1'b0, 'h0, 'h1, 1'b0);
  add_vec(fp_pkg::OP_FLT,     'h3F800000, 'h3F800000, 'h0, 1'b0, 'h0, 'h0, 1'b0);
  add_vec(fp_pkg::OP_FLE,     'h40000000, 'h3F800000, 'h0, 1'b0, 'h0, 'h0, 1'b0);
  add_vec(fp_pkg::OP_FEQ,     'h3F800000, 'h40000000, 'h0, 1'b0, 'h0, 'h0, 1'b0);
  add_vec(fp_pkg::OP_FEQ,     'h00000000, 'h80000000, 'h0, 1'b0, 'h0, 'h1, 1'b0);
  add_vec(fp_pkg::OP_FLE,     'h80000000, 'h00000000, 'h0, 1'b0, 'h0, 'h1, 1'b0);
  add_vec(fp_pkg::OP_FLT,     'h80000000, 'h00000000, 'h0, 1'b0, 'h0, 'h0, 1'b0);
  add_vec(fp_pkg::OP_FEQ,     'h7FC00000, 'h3F800000, 'h0, 1'b0, 'h0, 'h0, 1'b0);
  add_vec(fp_pkg::OP_FLT,     'h7FC00000, 'h3F800000, 'h0, 1'b1, 'h0, 'h0, 1'b1);
  add_vec(fp_pkg::OP_FEQ,     'h7F800001, 'h3F800000, 'h0, 1'b0, 'h0, 'h0, 1'b1);
  add_vec(fp_pkg::OP_FLE,     'h3F800000, 'h7FC00000, 'h0, 1'b0, 'h0, 'h0, 1'b1);
  // Classify, one value per class, the third entry clears with nothing pending
  add_vec(fp_pkg::OP_FCLASS,  'hFF800000, 'h0, 'h0, 1'b0, 'h0, 'h001, 1'b0);
  add_vec(fp_pkg::OP_FCLASS,  'hBF800000, 'h0, 'h0, 1'b0, 'h0, 'h002, 1'b0);
  add_vec(fp_pkg::OP_FCLASS,  'h80000001, 'h0, 'h0, 1'b1, 'h0, 'h004, 1'b0);
  add_vec(fp_pkg::OP_FCLASS,  'h80000000, 'h0, 'h0, 1'b0, 'h0, 'h008, 1'b0);
  add_vec(fp_pkg::OP_FCLASS,  'h00000000, 'h0, 'h0, 1'b0, 'h0, 'h010, 1'b0);
  add_vec(fp_pkg::OP_FCLASS,  'h00000001, 'h0, 'h0, 1'b0, 'h0, 'h020, 1'b0);
  add_vec(fp_pkg::OP_FCLASS,  'h3F800000, 'h0, 'h0, 1'b0, 'h0, 'h040, 1'b0);
  add_vec(fp_pkg::OP_FCLASS,  'h7F800000, 'h0, 'h0, 1'b0, 'h0, 'h080, 1'b0);
  add_vec(fp_pkg::OP_FCLASS,  'h7F800001, 'h0, 'h0, 1'b0, 'h0, 'h100, 1'b0);
  add_vec(fp_pkg::OP_FCLASS,  'h7FC00000, 'h0, 'h0, 1'b0, 'h0, 'h200, 1'b0);
  // Bit moves
  add_vec(fp_pkg::OP_FMV_X_W, 'hC0490FDB, 'h0, 'h0, 1'b0, 'h0, 'hC0490FDB, 1'b0);
  add_vec(fp_pkg::OP_FMV_W_X, 'h0, 'h0, 'h12345678, 1'b0, 'h12345678, 'h0, 1'b0);
endtask

`endif

// ==== test/fpu_tb.sv ====
// FPU testbench with clock, reset, table-driven stimulus, reference timing model and checks
module fpu_tb;

  localparam int NUM_RANDOM = 6;  // Extra sign-injection requests

  logic                     clk;
  logic                     rst_n;
  logic                     start;
  fp_pkg::fp_op_e           op;
  fp_pkg::fp_word_t         operand_a;
  fp_pkg::fp_word_t         operand_b;
  fp_pkg::int_word_t        int_operand;
  logic                     nv_clear;
  logic                     done;
  fp_pkg::fp_word_t         fp_result;
  fp_pkg::int_word_t        int_result;
  logic                     op_nv;
  logic                     nv_sticky;

  // Request table, one entry per index
  fp_pkg::fp_op_e q_op[$];
  logic [31:0]    q_a[$];
  logic [31:0]    q_b[$];
  logic [31:0]    q_int[$];
  logic           q_clr[$];
  logic [31:0]    q_exp_fp[$];
  logic [31:0]    q_exp_int[$];
  logic           q_exp_nv[$];

  int cur_idx;       // Entry on the input side
  int exp_idx;       // Entry expected on the output side
  fp_pkg::fp_op_e exp_op;
  logic exp_done;
  logic [31:0] exp_fp;
  logic [31:0] exp_int;
  logic exp_nv;
  logic exp_sticky;  // Clear-then-OR reference

  int errors;
  int tests_done;
  int tests_failed;
  int test_errors;
  int total;
  int cycle_count;
  int cycle_limit;
  logic [31:0] rng;
  logic [31:0] ra;
  logic [31:0] rb;
  logic sgn;
  fp_pkg::fp_op_e rop;

  fpu_top i_dut (
    .clk(clk), .rst_n(rst_n), .start(start), .op(op),
    .operand_a(operand_a), .operand_b(operand_b), .int_operand(int_operand),
    .nv_clear(nv_clear), .done(done), .fp_result(fp_result),
    .int_result(int_result), .op_nv(op_nv), .nv_sticky(nv_sticky)
  );

  always #5 clk = ~clk;  // 10-unit period

  // ========================================
  // Table helpers
  // ========================================
  task automatic add_vec(input fp_pkg::fp_op_e o, input logic [31:0] a, input logic [31:0] b,
                         input logic [31:0] iv, input logic clr, input logic [31:0] efp,
                         input logic [31:0] eint, input logic env);
    q_op.push_back(o);
    q_a.push_back(a);
    q_b.push_back(b);
    q_int.push_back(iv);
    q_clr.push_back(clr);
    q_exp_fp.push_back(efp);
    q_exp_int.push_back(eint);
    q_exp_nv.push_back(env);
  endtask

  `include "fpu_vectors.svh"

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic drive_request(input int k);
    @(posedge clk);
    start       <= 1'b1;
    op          <= q_op[k];
    operand_a   <= q_a[k];
    operand_b   <= q_b[k];
    int_operand <= q_int[k];
    nv_clear    <= q_clr[k];
    cur_idx     <= k;
  endtask

  task automatic drive_idle();
    @(posedge clk);
    start    <= 1'b0;
    nv_clear <= 1'b0;
  endtask

  // ========================================
  // Reference timing model
  // ========================================
  always @(posedge clk) begin
    if (!rst_n) begin
      exp_done   <= 1'b0;
      exp_nv     <= 1'b0;
      exp_sticky <= 1'b0;
      exp_fp     <= '0;
      exp_int    <= '0;
    end else begin
      exp_sticky <= (exp_sticky & ~nv_clear) | exp_nv;  // Clear first, then OR
      exp_done   <= start;
      exp_idx    <= cur_idx;
      if (start) begin
        exp_op  <= q_op[cur_idx];
        exp_fp  <= q_exp_fp[cur_idx];
        exp_int <= q_exp_int[cur_idx];
        exp_nv  <= q_exp_nv[cur_idx];
      end else begin
        exp_nv <= 1'b0;
      end
    end
  end

  // Output checks on the falling edge, away from the update edge
  always @(negedge clk) begin
    if (rst_n === 1'b1) begin
      test_errors = errors;
      assert (done === exp_done) else begin
        $display("[ERROR] %0t: done is %b, expected %b", $time, done, exp_done);
        errors++;
      end
      if (exp_done) begin
        assert (fp_result === exp_fp) else begin
          $display("[ERROR] %0t: fp_result %h, expected %h", $time, fp_result, exp_fp);
          errors++;
        end
        assert (int_result === exp_int) else begin
          $display("[ERROR] %0t: int_result %h, expected %h", $time, int_result, exp_int);
          errors++;
        end
        assert (op_nv === exp_nv) else begin
          $display("[ERROR] %0t: op_nv %b, expected %b", $time, op_nv, exp_nv);
          errors++;
        end
      end
      assert (nv_sticky === exp_sticky) else begin
        $display("[ERROR] %0t: nv_sticky %b, expected %b", $time, nv_sticky, exp_sticky);
        errors++;
      end
      if (exp_done) begin
        tests_done++;
        if (errors != test_errors) tests_failed++;
        $display("test %0d %-10s %s", exp_idx, exp_op.name(),
                 (errors == test_errors) ? "ok" : "fail");
      end
    end
  end

  // Timeout guard, limit set once the table is built
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: done never arrived for all %0d requests", total);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // ========================================
  // Main sequence
  // ========================================
  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    start        = 1'b0;
    op           = fp_pkg::OP_FSGNJ;
    operand_a    = '0;
    operand_b    = '0;
    int_operand  = '0;
    nv_clear     = 1'b0;
    cur_idx      = 0;
    exp_idx      = 0;
    errors       = 0;
    tests_done   = 0;
    tests_failed = 0;
    cycle_count  = 0;
    rng          = 32'd74;
    load_table();
    for (int i = 0; i < NUM_RANDOM; i++) begin
      rng = xorshift32(rng);
      ra  = rng;
      rng = xorshift32(rng);
      rb  = rng;
      case (i % 3)
        0: begin
          rop = fp_pkg::OP_FSGNJ;
          sgn = rb[31];
        end
        1: begin
          rop = fp_pkg::OP_FSGNJN;
          sgn = ~rb[31];
        end
        default: begin
          rop = fp_pkg::OP_FSGNJX;
          sgn = ra[31] ^ rb[31];
        end
      endcase
      add_vec(rop, ra, rb, 'h0, 1'b0, {sgn, ra[30:0]}, 'h0, 1'b0);  // Magnitude of a kept
    end
    total       = q_op.size();
    cycle_limit = 4 * total + 100;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    // Idle after reset, all outputs low
    repeat (3) begin
      @(negedge clk);
      assert (!done && !op_nv && !nv_sticky && fp_result == 0 && int_result == 0) else begin
        $display("[ERROR] %0t: outputs not idle after reset", $time);
        errors++;
      end
    end
    // Single isolated request
    drive_request(0);
    drive_idle();
    while (tests_done < 1) @(posedge clk);
    drive_idle();
    // Back-to-back burst of the rest
    for (int k = 1; k < total; k++) drive_request(k);
    drive_idle();
    while (tests_done < total) @(posedge clk);
    repeat (3) drive_idle();  // No stray done pulses
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
             tests_done, tests_done - tests_failed, tests_failed, errors);
    if (errors == 0 && tests_done == total) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
